/* design/noc_flit_pkg.sv */
package noc_flit_pkg;

    // Two virtual channels per physical port
    localparam int NUM_VCS = 2;

    localparam int CFG_VALUE_W = 18;

    // Format codes in the top nibble of every flit
    localparam logic [3:0] FMT_DATA       = 4'h1;
    localparam logic [3:0] FMT_SWITCH_CFG = 4'h2;

    typedef struct packed {
        logic [3:0]  fmt;
        logic [4:0]  dest;
        logic [22:0] payload;
    } data_view_t;

    typedef struct packed {
        logic [3:0]             fmt;
        logic [4:0]             dest;
        logic [4:0]             addr;
        logic [CFG_VALUE_W-1:0] value;
    } cfg_view_t;

    // Same 32-bit word seen as data or as a register write
    typedef union packed {
        data_view_t data;
        cfg_view_t  cfg;
    } flit_word_u;

endpackage

/* design/noc_cfg_pkg.sv */
package noc_cfg_pkg;

    localparam int NODE_W = 5;

    // Top of the register map holds the node id
    localparam logic [NODE_W-1:0] NODE_ID_ADDR = 5'd31;

    // Route entries occupy the addresses below the node id register
    localparam int ROUTE_ADDR_LIMIT = 31;

    function automatic int port_w(input int num_ports);
        return (num_ports > 1) ? $clog2(num_ports) : 1;
    endfunction

    function automatic int route_entries(input int total_nodes);
        return (total_nodes < ROUTE_ADDR_LIMIT) ? total_nodes : ROUTE_ADDR_LIMIT;
    endfunction

endpackage

/* design/route_cfg_if.sv */
`timescale 1ns/100ps

interface route_cfg_if #(
    parameter int NUM_PORTS   = 4,
    parameter int TOTAL_NODES = 16
);
    localparam int PORT_W      = noc_cfg_pkg::port_w(NUM_PORTS);
    localparam int NUM_ENTRIES = noc_cfg_pkg::route_entries(TOTAL_NODES);

    // Register write from a claimed config flit
    logic                                  cfg_write;
    logic [noc_cfg_pkg::NODE_W-1:0]        cfg_addr;
    logic [noc_flit_pkg::CFG_VALUE_W-1:0]  cfg_value;

    // Register contents seen by route compute
    logic [noc_cfg_pkg::NODE_W-1:0]        node_id;
    logic [NUM_ENTRIES-1:0][PORT_W-1:0]    route_table;

    modport compute (output cfg_write, cfg_addr, cfg_value, input node_id, route_table);
    modport regs    (input cfg_write, cfg_addr, cfg_value, output node_id, route_table);
endinterface

// Head of each port-VC FIFO as seen by the allocator
interface buf_head_if #(
    parameter int NUM_PORTS = 4
);
    localparam int NUM_SLOTS = NUM_PORTS * noc_flit_pkg::NUM_VCS;
    localparam int PORT_W    = noc_cfg_pkg::port_w(NUM_PORTS);

    logic [NUM_SLOTS-1:0]                           head_valid;
    noc_flit_pkg::flit_word_u [NUM_SLOTS-1:0]       head_flit;
    logic [NUM_SLOTS-1:0][PORT_W-1:0]               head_port;
    logic [NUM_SLOTS-1:0]                           pop;

    modport buffers (output head_valid, head_flit, head_port, input pop);
    modport alloc   (input head_valid, head_flit, head_port, output pop);
endinterface

/* design/route_table_regs.sv */
`timescale 1ns/100ps

module route_table_regs #(
    parameter int NUM_PORTS   = 4,
    parameter int TOTAL_NODES = 16,
    localparam int PORT_W      = noc_cfg_pkg::port_w(NUM_PORTS),
    localparam int NUM_ENTRIES = noc_cfg_pkg::route_entries(TOTAL_NODES)
) (
    input logic       clk,
    input logic       arst_n,
    route_cfg_if.regs cfg
);
    logic [noc_cfg_pkg::NODE_W-1:0]     node_id_q;
    logic [NUM_ENTRIES-1:0][PORT_W-1:0] table_q;
    logic [PORT_W-1:0]                  new_port;

    // Only the low bits of the value carry the port index
    assign new_port = cfg.cfg_value[PORT_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            node_id_q <= '0;
            // Default route spreads nodes over ports in turn
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                table_q[i] <= PORT_W'(i % NUM_PORTS);
            end
        end else if (cfg.cfg_write) begin
            if (cfg.cfg_addr == noc_cfg_pkg::NODE_ID_ADDR) begin
                node_id_q <= cfg.cfg_value[noc_cfg_pkg::NODE_W-1:0];
            end else if (int'(cfg.cfg_addr) < NUM_ENTRIES && int'(new_port) < NUM_PORTS) begin
                table_q[cfg.cfg_addr] <= new_port;
            end
            // Anything else falls outside the register map
        end
    end

    assign cfg.node_id     = node_id_q;
    assign cfg.route_table = table_q;

endmodule

/* design/route_compute.sv */
`timescale 1ns/100ps

module route_compute #(
    parameter int NUM_PORTS   = 4,
    parameter int TOTAL_NODES = 16,
    localparam int PORT_W      = noc_cfg_pkg::port_w(NUM_PORTS),
    localparam int NUM_ENTRIES = noc_cfg_pkg::route_entries(TOTAL_NODES)
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic [NUM_PORTS-1:0]                    in_valid,
    input  noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] in_flit,
    input  logic [NUM_PORTS-1:0]                    in_vc,
    route_cfg_if.compute                            cfg,
    output logic [NUM_PORTS-1:0]                    wr_valid,
    output noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] wr_flit,
    output logic [NUM_PORTS-1:0]                    wr_vc,
    output logic [NUM_PORTS-1:0][PORT_W-1:0]        wr_port
);
    logic [NUM_PORTS-1:0]             cfg_hit;
    logic [NUM_PORTS-1:0]             claim;
    logic [NUM_PORTS-1:0][PORT_W-1:0] lookup_port;

    always_comb begin
        claim = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            // Ours if addressed to us, or to anyone while unnamed
            cfg_hit[p] = in_valid[p]
                && in_flit[p].cfg.fmt == noc_flit_pkg::FMT_SWITCH_CFG
                && (in_flit[p].cfg.dest == cfg.node_id || cfg.node_id == '0);
            // Lowest port takes the single register write slot
            if (cfg_hit[p] && claim == '0) begin
                claim[p] = 1'b1;
            end
            if (int'(in_flit[p].data.dest) < NUM_ENTRIES) begin
                lookup_port[p] = cfg.route_table[in_flit[p].data.dest];
            end else begin
                lookup_port[p] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_valid      <= '0;
            cfg.cfg_write <= 1'b0;
        end else begin
            wr_valid      <= in_valid & ~claim;
            cfg.cfg_write <= |claim;
        end
    end

    always_ff @(posedge clk) begin
        wr_flit <= in_flit;
        wr_vc   <= in_vc;
        wr_port <= lookup_port;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (claim[p]) begin
                cfg.cfg_addr  <= in_flit[p].cfg.addr;
                cfg.cfg_value <= in_flit[p].cfg.value;
            end
        end
    end

endmodule

/* design/input_vc_buffers.sv */
`timescale 1ns/100ps

module input_vc_buffers #(
    parameter int NUM_PORTS    = 4,
    parameter int BUFFER_DEPTH = 4,
    localparam int PORT_W = noc_cfg_pkg::port_w(NUM_PORTS)
) (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  logic [NUM_PORTS-1:0]                           wr_valid,
    input  noc_flit_pkg::flit_word_u [NUM_PORTS-1:0]       wr_flit,
    input  logic [NUM_PORTS-1:0]                           wr_vc,
    input  logic [NUM_PORTS-1:0][PORT_W-1:0]               wr_port,
    output logic [NUM_PORTS-1:0][noc_flit_pkg::NUM_VCS-1:0] buffer_available,
    buf_head_if.buffers                                    heads
);
    localparam int NV        = noc_flit_pkg::NUM_VCS;
    localparam int NUM_SLOTS = NUM_PORTS * NV;
    localparam int PTR_W     = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int CNT_W     = $clog2(BUFFER_DEPTH + 1);

    // Slot s holds port s/NV, VC s%NV
    noc_flit_pkg::flit_word_u [BUFFER_DEPTH-1:0] mem_flit [NUM_SLOTS];
    logic [BUFFER_DEPTH-1:0][PORT_W-1:0]         mem_port [NUM_SLOTS];
    logic [NUM_SLOTS-1:0][PTR_W-1:0]             rd_ptr_q;
    logic [NUM_SLOTS-1:0][PTR_W-1:0]             wr_ptr_q;
    logic [NUM_SLOTS-1:0][CNT_W-1:0]             count_q;
    logic [NUM_SLOTS-1:0]                        push;
    logic [NUM_SLOTS-1:0]                        pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (int'(ptr) == BUFFER_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pop[s] = heads.pop[s] && count_q[s] != '0;
            // A full FIFO still accepts when its head leaves this cycle
            push[s] = wr_valid[s / NV] && int'(wr_vc[s / NV]) == s % NV
                && (count_q[s] != CNT_W'(BUFFER_DEPTH) || pop[s]);
            heads.head_valid[s] = count_q[s] != '0;
            heads.head_flit[s]  = mem_flit[s][rd_ptr_q[s]];
            heads.head_port[s]  = mem_port[s][rd_ptr_q[s]];
            buffer_available[s / NV][s % NV] = count_q[s] != CNT_W'(BUFFER_DEPTH);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (push[s]) begin
                    wr_ptr_q[s] <= next_ptr(wr_ptr_q[s]);
                end
                if (pop[s]) begin
                    rd_ptr_q[s] <= next_ptr(rd_ptr_q[s]);
                end
                count_q[s] <= count_q[s] + CNT_W'(push[s]) - CNT_W'(pop[s]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (push[s]) begin
                mem_flit[s][wr_ptr_q[s]] <= wr_flit[s / NV];
                mem_port[s][wr_ptr_q[s]] <= wr_port[s / NV];
            end
        end
    end

endmodule

/* design/switch_allocator.sv */
`timescale 1ns/100ps

module switch_allocator #(
    parameter int NUM_PORTS    = 4,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    buf_head_if.alloc                                heads,
    input  logic [NUM_PORTS-1:0]                     credit_return,
    output logic [NUM_PORTS-1:0]                     out_valid,
    output noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] out_flit,
    output logic [NUM_PORTS-1:0]                     out_vc
);
    localparam int NUM_SLOTS = NUM_PORTS * noc_flit_pkg::NUM_VCS;
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int CREDIT_W  = $clog2(BUFFER_DEPTH + 1);

    logic [NUM_PORTS-1:0][SLOT_W-1:0]   prio_q;
    logic [NUM_PORTS-1:0][CREDIT_W-1:0] credit_q;
    logic [NUM_PORTS-1:0]               grant;
    logic [NUM_PORTS-1:0][SLOT_W-1:0]   winner;

    // One rotating-priority search per output
    always_comb begin
        int idx;
        grant     = '0;
        winner    = '0;
        heads.pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int k = 0; k < NUM_SLOTS; k++) begin
                idx = int'(prio_q[o]) + k;
                if (idx >= NUM_SLOTS) begin
                    idx = idx - NUM_SLOTS;
                end
                if (!grant[o] && credit_q[o] != '0 && heads.head_valid[idx]
                        && int'(heads.head_port[idx]) == o) begin
                    grant[o]  = 1'b1;
                    winner[o] = SLOT_W'(idx);
                end
            end
            // Each slot targets one output, so pops never collide
            if (grant[o]) begin
                heads.pop[winner[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= '0;
            prio_q    <= '0;
            for (int o = 0; o < NUM_PORTS; o++) begin
                credit_q[o] <= CREDIT_W'(BUFFER_DEPTH);
            end
        end else begin
            out_valid <= grant;
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (grant[o]) begin
                    // Winner drops to lowest priority
                    prio_q[o] <= (int'(winner[o]) == NUM_SLOTS - 1) ? '0 : winner[o] + 1'b1;
                end
                credit_q[o] <= credit_q[o] - CREDIT_W'(grant[o]) + CREDIT_W'(credit_return[o]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (grant[o]) begin
                out_flit[o] <= heads.head_flit[winner[o]];
                out_vc[o]   <= 1'(int'(winner[o]) % noc_flit_pkg::NUM_VCS);
            end
        end
    end

endmodule

/* design/noc_switch.sv */
`timescale 1ns/100ps

module noc_switch #(
    parameter int NUM_PORTS    = 4,
    parameter int BUFFER_DEPTH = 4,
    parameter int TOTAL_NODES  = 16,
    localparam int PORT_W = noc_cfg_pkg::port_w(NUM_PORTS)
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic [NUM_PORTS-1:0]                            in_valid,
    input  noc_flit_pkg::flit_word_u [NUM_PORTS-1:0]        in_flit,
    input  logic [NUM_PORTS-1:0]                            in_vc,
    input  logic [NUM_PORTS-1:0]                            credit_return,
    output logic [NUM_PORTS-1:0][noc_flit_pkg::NUM_VCS-1:0] buffer_available,
    output logic [NUM_PORTS-1:0]                            out_valid,
    output noc_flit_pkg::flit_word_u [NUM_PORTS-1:0]        out_flit,
    output logic [NUM_PORTS-1:0]                            out_vc,
    output logic [noc_cfg_pkg::NODE_W-1:0]                  node_id
);
    // Route compute to buffer write stage
    logic [NUM_PORTS-1:0]                     wr_valid;
    noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] wr_flit;
    logic [NUM_PORTS-1:0]                     wr_vc;
    logic [NUM_PORTS-1:0][PORT_W-1:0]         wr_port;

    route_cfg_if #(.NUM_PORTS(NUM_PORTS), .TOTAL_NODES(TOTAL_NODES)) cfg_if ();
    buf_head_if #(.NUM_PORTS(NUM_PORTS)) head_if ();

    route_compute #(.NUM_PORTS(NUM_PORTS), .TOTAL_NODES(TOTAL_NODES)) u_route_compute (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_flit(in_flit), .in_vc(in_vc),
        .cfg(cfg_if.compute),
        .wr_valid(wr_valid), .wr_flit(wr_flit), .wr_vc(wr_vc), .wr_port(wr_port)
    );

    route_table_regs #(.NUM_PORTS(NUM_PORTS), .TOTAL_NODES(TOTAL_NODES)) u_route_table_regs (
        .clk(clk), .arst_n(arst_n), .cfg(cfg_if.regs)
    );

    input_vc_buffers #(.NUM_PORTS(NUM_PORTS), .BUFFER_DEPTH(BUFFER_DEPTH)) u_buffers (
        .clk(clk), .arst_n(arst_n),
        .wr_valid(wr_valid), .wr_flit(wr_flit), .wr_vc(wr_vc), .wr_port(wr_port),
        .buffer_available(buffer_available),
        .heads(head_if.buffers)
    );

    switch_allocator #(.NUM_PORTS(NUM_PORTS), .BUFFER_DEPTH(BUFFER_DEPTH)) u_allocator (
        .clk(clk), .arst_n(arst_n),
        .heads(head_if.alloc),
        .credit_return(credit_return),
        .out_valid(out_valid), .out_flit(out_flit), .out_vc(out_vc)
    );

    assign node_id = cfg_if.node_id;

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end
endmodule

/* verification/tb_noc_switch.sv */
`timescale 1ns/100ps

module tb_noc_switch;
    localparam int NUM_PORTS    = 4;
    localparam int BUFFER_DEPTH = 4;
    localparam int TOTAL_NODES  = 16;
    localparam int NV           = noc_flit_pkg::NUM_VCS;

    // One flit still owed by an input source
    typedef struct packed {
        logic [31:0] flit;
        int          outp;
        int          lat;
        int          sent;
        int          line;
    } expect_t;

    logic                                     clk;
    logic                                     arst_n;
    logic [NUM_PORTS-1:0]                     in_valid;
    noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] in_flit;
    logic [NUM_PORTS-1:0]                     in_vc;
    logic [NUM_PORTS-1:0]                     credit_return;
    logic [NUM_PORTS-1:0][NV-1:0]             buffer_available;
    logic [NUM_PORTS-1:0]                     out_valid;
    noc_flit_pkg::flit_word_u [NUM_PORTS-1:0] out_flit;
    logic [NUM_PORTS-1:0]                     out_vc;
    logic [noc_cfg_pkg::NODE_W-1:0]           node_id;

    // Case file columns
    string       c_name [$];
    string       c_op [$];
    int          c_port [$];
    int          c_vc [$];
    logic [31:0] c_word [$];
    int          c_out [$];
    int          c_lat [$];

    // Reference state of the router
    int          route_ref [TOTAL_NODES];
    logic [4:0]  node_ref;
    expect_t     pending [NUM_PORTS*NV][$];
    logic [NUM_PORTS-1:0] hold;
    int          manual_left [NUM_PORTS];
    int          cycle;
    int          errors;
    int          limit_cycles;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) clock_gen (.clk(clk), .arst_n(arst_n));

    noc_switch #(
        .NUM_PORTS(NUM_PORTS), .BUFFER_DEPTH(BUFFER_DEPTH), .TOTAL_NODES(TOTAL_NODES)
    ) dut (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_flit(in_flit), .in_vc(in_vc),
        .credit_return(credit_return), .buffer_available(buffer_available),
        .out_valid(out_valid), .out_flit(out_flit), .out_vc(out_vc), .node_id(node_id)
    );

    task automatic check_value(input int line, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", c_name[line], expected, actual);
        end
    endtask

    function automatic int outstanding();
        int total;
        total = 0;
        foreach (pending[s]) begin
            total += pending[s].size();
        end
        return total;
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        string name;
        string op;
        string out_s;
        string lat_s;
        int    port;
        int    vc;
        logic [31:0] word;
        fd = $fopen("verification/switch_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the case file verification/switch_cases.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %d %d %h %s %s", name, op, port, vc, word, out_s, lat_s);
                if (n == 7) begin
                    c_name.push_back(name);
                    c_op.push_back(op);
                    c_port.push_back(port);
                    c_vc.push_back(vc);
                    c_word.push_back(word);
                    c_out.push_back(out_s == "-" ? -1 : out_s.atoi());
                    c_lat.push_back(lat_s == "-" ? -1 : lat_s.atoi());
                end
            end
        end
        $fclose(fd);
    endtask

    // Claim rule and route lookup; -1 means the router keeps the flit
    task automatic predict_route(input logic [31:0] w, output int outp);
        noc_flit_pkg::flit_word_u f;
        f = w;
        outp = (int'(f.data.dest) < TOTAL_NODES) ? route_ref[f.data.dest] : 0;
        if (f.cfg.fmt == noc_flit_pkg::FMT_SWITCH_CFG
                && (f.cfg.dest == node_ref || node_ref == '0)) begin
            outp = -1;
            if (f.cfg.addr == noc_cfg_pkg::NODE_ID_ADDR) begin
                node_ref = f.cfg.value[4:0];
            end else if (int'(f.cfg.addr) < TOTAL_NODES) begin
                route_ref[f.cfg.addr] = int'(f.cfg.value);
            end
        end
    endtask

    // Order is only kept per input source, so look at every source head
    task automatic match_output(input int o);
        int      s;
        expect_t e;
        for (int p = 0; p < NUM_PORTS; p++) begin
            s = p * NV + int'(out_vc[o]);
            if (pending[s].size() > 0 && pending[s][0].outp == o
                    && pending[s][0].flit == out_flit[o]) begin
                e = pending[s].pop_front();
                // Counted in clock edges after the sampling edge
                if (e.lat >= 0) begin
                    check_value(e.line, e.lat, cycle - e.sent - 1);
                end
                return;
            end
        end
        errors++;
        $display("Output %0d sent flit %h on VC %0d that no input was waiting for",
                 o, out_flit[o], out_vc[o]);
    endtask

    // One falling edge: collect outputs, then drive credits
    task automatic step();
        @(negedge clk);
        cycle++;
        in_valid = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o]) begin
                match_output(o);
            end
            credit_return[o] = (out_valid[o] && !hold[o]) || manual_left[o] > 0;
            if (manual_left[o] > 0) begin
                manual_left[o]--;
                if (manual_left[o] == 0) begin
                    hold[o] = 1'b0;
                end
            end
        end
    endtask

    task automatic run_case(input int i);
        int      outp;
        int      p;
        expect_t e;
        p = c_port[i];
        if (c_op[i] == "wait") begin
            repeat (p) step();
            check_value(i, c_out[i], outstanding());
            check_value(i, 32'(node_ref), 32'(node_id));
        end else if (c_op[i] == "avail") begin
            check_value(i, c_out[i], 32'(buffer_available[p][c_vc[i]]));
        end else if (c_op[i] == "credits") begin
            if (c_vc[i] == 0) begin
                hold[p] = 1'b1;
            end else begin
                manual_left[p] = c_vc[i];
            end
        end else begin
            if (!buffer_available[p][c_vc[i]]) begin
                errors++;
                $display("%s drives port %0d VC %0d while its buffer is full", c_name[i], p, c_vc[i]);
            end
            in_valid[p] = 1'b1;
            in_flit[p]  = c_word[i];
            in_vc[p]    = c_vc[i][0];
            predict_route(c_word[i], outp);
            if (outp != c_out[i]) begin
                errors++;
                $display("%s lists output %0d but the route rules give %0d", c_name[i], c_out[i], outp);
            end
            if (outp >= 0) begin
                e.flit = c_word[i];
                e.outp = outp;
                e.lat  = c_lat[i];
                e.sent = cycle;
                e.line = i;
                pending[p * NV + c_vc[i]].push_back(e);
            end
            // Lines marked add share the cycle with the next line
            if (c_op[i] != "add") begin
                step();
            end
        end
    endtask

    initial begin
        in_valid      = '0;
        in_flit       = '0;
        in_vc         = '0;
        credit_return = '0;
        hold          = '0;
        node_ref      = '0;
        cycle         = 0;
        errors        = 0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            manual_left[o] = 0;
        end
        for (int n = 0; n < TOTAL_NODES; n++) begin
            route_ref[n] = n % NUM_PORTS;
        end
        load_cases();
        limit_cycles = 50 * c_name.size() + 200;
        @(posedge arst_n);
        repeat (2) step();
        for (int i = 0; i < c_name.size(); i++) begin
            run_case(i);
        end
        while (outstanding() > 0) begin
            step();
        end
        repeat (4) step();
        $display("Finished %0d case lines with %0d errors", c_name.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: flits still missing after %0d cycles", limit_cycles);
        $display("** FAIL **");
        $finish;
    end
endmodule

/* verification/switch_cases.txt */
# name op port vc flit out latency
# wait: port = cycles, out = flits still owed; avail: out = flag; credits: vc = pulses, 0 holds
route_dflt send 0 0 12800011 1 2
route_dflt send 2 1 17000022 2 2
route_dflt wait 8 0 00000000 0 -
route_prog config 1 0 20140003 - -
route_prog wait 4 0 00000000 0 -
route_prog send 3 0 12800033 3 2
route_prog wait 8 0 00000000 0 -
node_claim config 0 1 207c0007 - -
node_claim wait 4 0 00000000 0 -
node_claim config 2 0 24940001 1 2
node_claim config 1 1 23a40002 - -
node_claim wait 8 0 00000000 0 -
backpr credits 3 0 00000000 - -
contend add 0 0 118000a1 3 -
contend add 1 1 118000a2 3 -
contend add 3 0 118000a3 3 -
contend send 2 1 118000a4 3 -
contend add 0 0 118000a5 3 -
contend send 1 1 118000a6 3 -
backpr wait 12 0 00000000 2 -
buf_full send 3 1 118000b1 3 -
buf_full send 3 1 118000b2 3 -
buf_full send 3 1 118000b3 3 -
buf_full send 3 1 118000b4 3 -
buf_full wait 4 0 00000000 6 -
buf_full avail 3 1 00000000 0 -
buf_full avail 3 0 00000000 1 -
backpr credits 3 10 00000000 - -
backpr wait 24 0 00000000 0 -

/* flist.f */
design/noc_flit_pkg.sv
design/noc_cfg_pkg.sv
design/route_cfg_if.sv
design/route_table_regs.sv
design/route_compute.sv
design/input_vc_buffers.sv
design/switch_allocator.sv
design/noc_switch.sv
verification/tb_clock_gen.sv
verification/tb_noc_switch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the NoC switch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_noc_switch -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_noc_switch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
exit 0
